// File: verilog/frv_pkg.sv
/*
 * Shared constants for the RV32 writeback stage: core widths, functional
 * unit one-hot positions, micro-op encodings and trap cause codes.
 * Modules pull these in with a wildcard import.
 */

package frv_pkg;

    // Core widths
    // --------------------------------------------------
    localparam int XLEN = 32;                   // Data path width
    localparam int XL   = XLEN - 1;             // Top bit index

    // Functional unit positions in the one-hot s4_fu field
    // --------------------------------------------------
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;

    // CSR micro-op flags, bit positions in s4_uop
    // --------------------------------------------------
    localparam int CSR_READ  = 4;
    localparam int CSR_WRITE = 3;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 1;

    // Control flow micro-op codes, anything else is a branch not taken
    // --------------------------------------------------
    localparam logic [4:0] CFU_TAKEN  = 5'b01001; // Branch taken
    localparam logic [4:0] CFU_JALI   = 5'b01010; // JAL, links
    localparam logic [4:0] CFU_JALR   = 5'b01011; // JALR, links
    localparam logic [4:0] CFU_EBREAK = 5'b01101;
    localparam logic [4:0] CFU_ECALL  = 5'b01110;
    localparam logic [4:0] CFU_MRET   = 5'b01111;

    // LSU micro-op fields, size code lives in s4_uop[2:1]
    // --------------------------------------------------
    localparam int LSU_SIGNED = 0;
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;

    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Trap causes as written to mcause
    localparam logic [5:0] TRAP_BREAKPT  = 6'd3;
    localparam logic [5:0] TRAP_LDACCESS = 6'd5;
    localparam logic [5:0] TRAP_STACCESS = 6'd7;
    localparam logic [5:0] TRAP_ECALLM   = 6'd11;

endpackage

// File: verilog/frv_wb_ctrl.sv
/*
 * Progress tracking for the instruction held in the writeback stage.
 * Produces the stage stall, the retire pulse, the first-cycle CSR strobe
 * and the pending load/store response level.
 */

`timescale 1ns/100ps

module frv_wb_ctrl import frv_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       s4_valid,   // Stage inputs valid
    input  logic [4:0] s4_fu,      // One-hot functional unit
    input  logic       cf_req,     // From the control flow unit
    input  logic       cf_ack,
    input  logic       dmem_recv,
    output logic       s4_busy,
    output logic       retire,     // One pulse per instruction
    output logic       csr_first,  // First cycle of a CSR op
    output logic       lsu_wait,   // Memory response still expected
    output logic       cf_done     // Change made, stage still stalled
);

typedef enum logic [1:0] {
    IDLE,        // First cycle, or no instruction
    WAIT_LSU,    // Waiting on the memory response
    WAIT_CF,     // Response seen, change request pending
    DONE_STALL   // Change completed, memory still outstanding
} wb_state_t;

wb_state_t state;
wb_state_t n_state;

logic fu_lsu;
logic fu_csr;
logic lsu_pend;
logic cf_fire;

// Decode
// --------------------------------------------------

assign fu_lsu   = s4_valid && s4_fu[P_FU_LSU];
assign fu_csr   = s4_valid && s4_fu[P_FU_CSR];

assign lsu_wait = fu_lsu && (state != WAIT_CF);
assign lsu_pend = lsu_wait && !dmem_recv;       // Still waiting after this cycle
assign cf_fire  = cf_req && cf_ack;

// Stall and retire
// --------------------------------------------------

assign s4_busy   = lsu_pend || (cf_req && !cf_ack);
assign retire    = s4_valid && !s4_busy;
assign csr_first = fu_csr && (state == IDLE);
assign cf_done   = (state == DONE_STALL);

always_comb begin
    n_state = IDLE;                             // Retire or nothing held
    if (s4_busy) begin
        if (lsu_pend) begin
            // A change can complete while the response is outstanding
            n_state = (cf_fire || cf_done) ? DONE_STALL : WAIT_LSU;
        end else begin
            n_state = WAIT_CF;
        end
    end
end

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        state <= IDLE;
    end else begin
        state <= n_state;
    end
end

// Protocol checks
// --------------------------------------------------

// The memory side only answers an access that is still waiting
a_recv_has_wait: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    dmem_recv |-> lsu_wait
);

a_busy_has_valid: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    $rose(s4_busy) |-> s4_valid
);

endmodule

// File: verilog/frv_wb_cf_unit.sv
/*
 * Control flow and trap handling for the writeback stage. Holds the stage
 * PC, raises and holds cf_req until acknowledged, selects the target and
 * forms the trap cause. Also provides the link value for JAL/JALR.
 */

`timescale 1ns/100ps

module frv_wb_cf_unit import frv_pkg::*; #(
    parameter logic [XL:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        s4_valid,
    input  logic [ 4:0] s4_fu,
    input  logic [ 4:0] s4_uop,
    input  logic [ 1:0] s4_size,      // Instruction size in halfwords
    input  logic [XL:0] s4_opr_a,     // Jump target or upstream cause
    input  logic        s4_trap,      // Upstream trap
    input  logic        lsu_error,    // Bus error in this cycle
    input  logic        lsu_store,
    input  logic        cf_ack,
    input  logic        cf_done,
    input  logic        retire,
    input  logic [XL:0] csr_mepc,
    input  logic [XL:0] csr_mtvec,
    output logic        cf_req,
    output logic [XL:0] cf_target,
    output logic [XL:0] link_wdata,
    output logic        trap_cpu,
    output logic [ 5:0] trap_cause,
    output logic [XL:0] trap_pc,
    output logic        exec_mret,
    output logic [XL:0] pc
);

logic fu_cfu;
logic cfu_taken;
logic cfu_ebreak;
logic cfu_ecall;
logic cfu_mret;
logic lsu_err_q;   // Bus error seen, waiting on the trap request
logic lsu_trap;
logic tgt_trap;

// Decode
// --------------------------------------------------

assign fu_cfu     = s4_valid && s4_fu[P_FU_CFU];
assign cfu_taken  = fu_cfu && (s4_uop == CFU_TAKEN || s4_uop == CFU_JALI ||
                               s4_uop == CFU_JALR);
assign cfu_ebreak = fu_cfu && (s4_uop == CFU_EBREAK);
assign cfu_ecall  = fu_cfu && (s4_uop == CFU_ECALL);
assign cfu_mret   = fu_cfu && (s4_uop == CFU_MRET);

assign lsu_trap   = lsu_error || lsu_err_q;
assign tgt_trap   = cfu_ebreak || cfu_ecall || (s4_valid && s4_trap) || lsu_trap;

// Request and target
// --------------------------------------------------

assign cf_req    = (cfu_taken || cfu_mret || tgt_trap) && !cf_done;

assign cf_target = tgt_trap ? csr_mtvec :   // Traps win over jumps
                   cfu_mret ? csr_mepc  :
                              s4_opr_a  ;

assign exec_mret = cfu_mret && retire;

// Trap reporting
assign trap_cpu   = tgt_trap;
assign trap_cause = lsu_trap && !lsu_store ? TRAP_LDACCESS :
                    lsu_trap               ? TRAP_STACCESS :
                    cfu_ebreak             ? TRAP_BREAKPT  :
                    cfu_ecall              ? TRAP_ECALLM   :
                                             s4_opr_a[5:0] ;
assign trap_pc    = pc;

// Stage PC
// --------------------------------------------------

assign link_wdata = pc + {{(XLEN-3){1'b0}}, s4_size, 1'b0};

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        pc        <= PC_RESET_VALUE;
        lsu_err_q <= 1'b0;
    end else begin
        if (cf_req && cf_ack) begin
            pc <= cf_target;
        end else if (retire && !cf_done) begin
            pc <= link_wdata;                   // Next sequential PC
        end
        if (retire) begin
            lsu_err_q <= 1'b0;
        end else if (lsu_error) begin
            lsu_err_q <= 1'b1;
        end
    end
end

a_req_held: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    (cf_req && !cf_ack) |=> (cf_req && $stable(cf_target))
);

endmodule

// File: verilog/frv_wb_load_align.sv
/*
 * Load data alignment. Moves the addressed byte or halfword of a memory
 * word down to bit 0 and zero or sign extends it to the full data width.
 * Purely combinational.
 */

`timescale 1ns/100ps

module frv_wb_load_align import frv_pkg::*; (
    input  logic [XL:0] dmem_rdata,   // Raw memory word
    input  logic [ 1:0] addr_lo,      // Byte offset in the word
    input  logic [ 1:0] lsu_size,
    input  logic        lsu_signed,
    output logic [XL:0] load_data
);

logic [XL:0] rdata_sh;
logic        sign_b;
logic        sign_h;

// Offset in bytes becomes a shift in bits
assign rdata_sh = dmem_rdata >> {addr_lo, 3'b000};

assign sign_b   = lsu_signed && rdata_sh[7];
assign sign_h   = lsu_signed && rdata_sh[15];

// Extension
// --------------------------------------------------

always_comb begin
    case (lsu_size)
        LSU_BYTE: begin
            load_data = {{(XLEN-8){sign_b}}, rdata_sh[7:0]};
        end
        LSU_HALF: begin
            load_data = {{(XLEN-16){sign_h}}, rdata_sh[15:0]};
        end
        LSU_WORD: begin
            load_data = rdata_sh;
        end
        default: begin
            load_data = rdata_sh;               // Unused size code
        end
    endcase
end

endmodule

// File: verilog/frv_retire_counter.sv
/*
 * Count of retired instructions, used for minstret and trace ordering.
 * Wraps at the top of its range.
 */

`timescale 1ns/100ps

module frv_retire_counter #(
    parameter int RET_CNT_W = 64
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 retire,    // One pulse per instruction
    output logic [RET_CNT_W-1:0] instret
);

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        instret <= '0;
    end else if (retire) begin
        instret <= instret + {{(RET_CNT_W-1){1'b0}}, 1'b1};
    end
end

// Monotonic apart from the wrap
a_no_decrease: assert property (
    @(posedge g_clk) disable iff (!g_resetn)
    (instret != '1) |=> (instret >= $past(instret))
);

endmodule

// File: verilog/frv_wb_gpr_select.sv
/*
 * GPR writeback selection. Picks the write enable and data from the
 * functional unit results and mirrors them on the forwarding outputs.
 */

`timescale 1ns/100ps

module frv_wb_gpr_select import frv_pkg::*; (
    input  logic        s4_valid,
    input  logic [ 4:0] s4_fu,
    input  logic [ 4:0] s4_uop,
    input  logic [ 4:0] s4_rd,
    input  logic [XL:0] s4_opr_a,     // ALU and MUL result
    input  logic        s4_trap,
    input  logic        csr_first,
    input  logic [XL:0] csr_rdata,
    input  logic [XL:0] link_wdata,
    input  logic [XL:0] load_data,
    input  logic        dmem_recv,
    input  logic        dmem_error,
    input  logic        lsu_wait,
    output logic        gpr_wen,
    output logic [ 4:0] gpr_rd,
    output logic [XL:0] gpr_wdata,
    output logic [ 4:0] fwd_s4_rd,
    output logic [XL:0] fwd_s4_wdata,
    output logic        fwd_s4_load,
    output logic        fwd_s4_csr
);

logic alu_wen;
logic mul_wen;
logic csr_wen;
logic cfu_wen;
logic lsu_wen;

assign alu_wen = s4_valid && s4_fu[P_FU_ALU];
assign mul_wen = s4_valid && s4_fu[P_FU_MUL];
assign csr_wen = csr_first && s4_uop[CSR_READ];     // Read value only valid now
assign cfu_wen = s4_valid && s4_fu[P_FU_CFU] &&
                 (s4_uop == CFU_JALI || s4_uop == CFU_JALR);
assign lsu_wen = lsu_wait && dmem_recv && s4_uop[LSU_LOAD] && !dmem_error;

// Write port
// --------------------------------------------------

assign gpr_wen   = !s4_trap && (alu_wen || mul_wen || csr_wen || cfu_wen || lsu_wen);
assign gpr_rd    = s4_rd;
assign gpr_wdata = {XLEN{alu_wen || mul_wen}} & s4_opr_a   |
                   {XLEN{csr_wen}}            & csr_rdata  |
                   {XLEN{cfu_wen}}            & link_wdata |
                   {XLEN{lsu_wen}}            & load_data  ;

assign fwd_s4_rd    = s4_rd;
assign fwd_s4_wdata = gpr_wdata;
assign fwd_s4_load  = s4_valid && s4_fu[P_FU_LSU] && s4_uop[LSU_LOAD];
assign fwd_s4_csr   = s4_valid && s4_fu[P_FU_CSR];

endmodule

// File: verilog/frv_pipeline_writeback.sv
/*
 * Writeback stage of the RV32 pipeline. Finishes each instruction: GPR
 * writeback, load data return, CSR access, control flow changes and traps,
 * trace output and the retired instruction count.
 */

`timescale 1ns/100ps

module frv_pipeline_writeback import frv_pkg::*; #(
    parameter logic [XL:0] PC_RESET_VALUE = 32'h8000_0000,
    parameter int          RET_CNT_W      = 64
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 s4_valid,
    output logic                 s4_busy,
    input  logic [ 4:0]          s4_rd,
    input  logic [XL:0]          s4_opr_a,
    input  logic [XL:0]          s4_opr_b,     // CSR address or LSU address
    input  logic [ 4:0]          s4_uop,
    input  logic [ 4:0]          s4_fu,
    input  logic                 s4_trap,
    input  logic [ 1:0]          s4_size,
    input  logic [31:0]          s4_instr,
    output logic [ 4:0]          fwd_s4_rd,
    output logic [XL:0]          fwd_s4_wdata,
    output logic                 fwd_s4_load,
    output logic                 fwd_s4_csr,
    output logic                 gpr_wen,
    output logic [ 4:0]          gpr_rd,
    output logic [XL:0]          gpr_wdata,
    output logic                 trap_cpu,
    output logic [ 5:0]          trap_cause,
    output logic [XL:0]          trap_pc,
    output logic                 exec_mret,
    input  logic [XL:0]          csr_mepc,
    input  logic [XL:0]          csr_mtvec,
    output logic                 csr_en,
    output logic                 csr_wr,
    output logic                 csr_wr_set,
    output logic                 csr_wr_clr,
    output logic [11:0]          csr_addr,
    output logic [XL:0]          csr_wdata,
    input  logic [XL:0]          csr_rdata,
    output logic                 cf_req,
    output logic [XL:0]          cf_target,
    input  logic                 cf_ack,
    output logic                 hold_lsu_req,
    input  logic                 dmem_recv,
    output logic                 dmem_ack,
    input  logic                 dmem_error,
    input  logic [XL:0]          dmem_rdata,
    output logic [XL:0]          trs_pc,
    output logic [31:0]          trs_instr,
    output logic                 trs_valid,
    output logic [RET_CNT_W-1:0] instret
);

logic        retire;
logic        csr_first;
logic        lsu_wait;
logic        lsu_error;
logic        cf_done;
logic        [XL:0] pc;
logic [XL:0] link_wdata;
logic [XL:0] load_data;

// Direct outputs
// --------------------------------------------------

assign csr_en       = csr_first;
assign csr_wr       = csr_first && s4_uop[CSR_WRITE];
assign csr_wr_set   = csr_first && s4_uop[CSR_SET];
assign csr_wr_clr   = csr_first && s4_uop[CSR_CLEAR];
assign csr_addr     = s4_opr_b[11:0];
assign csr_wdata    = s4_opr_a;

assign dmem_ack     = lsu_wait;
assign lsu_error    = lsu_wait && dmem_recv && dmem_error;
assign hold_lsu_req = cf_req || lsu_wait;       // No new accesses until settled

assign trs_pc       = pc;
assign trs_instr    = s4_instr;
assign trs_valid    = retire;

// Blocks
// --------------------------------------------------

frv_wb_ctrl u_ctrl (
    .g_clk(g_clk), .g_resetn(g_resetn), .s4_valid(s4_valid), .s4_fu(s4_fu),
    .cf_req(cf_req), .cf_ack(cf_ack), .dmem_recv(dmem_recv),
    .s4_busy(s4_busy), .retire(retire), .csr_first(csr_first),
    .lsu_wait(lsu_wait), .cf_done(cf_done)
);

frv_wb_cf_unit #(.PC_RESET_VALUE(PC_RESET_VALUE)) u_cf_unit (
    .g_clk(g_clk), .g_resetn(g_resetn), .s4_valid(s4_valid), .s4_fu(s4_fu),
    .s4_uop(s4_uop), .s4_size(s4_size), .s4_opr_a(s4_opr_a), .s4_trap(s4_trap),
    .lsu_error(lsu_error), .lsu_store(s4_uop[LSU_STORE]), .cf_ack(cf_ack),
    .cf_done(cf_done), .retire(retire), .csr_mepc(csr_mepc),
    .csr_mtvec(csr_mtvec), .cf_req(cf_req), .cf_target(cf_target),
    .link_wdata(link_wdata), .trap_cpu(trap_cpu), .trap_cause(trap_cause),
    .trap_pc(trap_pc), .exec_mret(exec_mret), .pc(pc)
);

frv_wb_load_align u_load_align (
    .dmem_rdata(dmem_rdata), .addr_lo(s4_opr_b[1:0]), .lsu_size(s4_uop[2:1]),
    .lsu_signed(s4_uop[LSU_SIGNED]), .load_data(load_data)
);

frv_retire_counter #(.RET_CNT_W(RET_CNT_W)) u_retire_counter (
    .g_clk(g_clk), .g_resetn(g_resetn), .retire(retire), .instret(instret)
);

frv_wb_gpr_select u_gpr_select (
    .s4_valid(s4_valid), .s4_fu(s4_fu), .s4_uop(s4_uop), .s4_rd(s4_rd),
    .s4_opr_a(s4_opr_a), .s4_trap(s4_trap), .csr_first(csr_first),
    .csr_rdata(csr_rdata), .link_wdata(link_wdata), .load_data(load_data),
    .dmem_recv(dmem_recv), .dmem_error(dmem_error), .lsu_wait(lsu_wait),
    .gpr_wen(gpr_wen), .gpr_rd(gpr_rd), .gpr_wdata(gpr_wdata),
    .fwd_s4_rd(fwd_s4_rd), .fwd_s4_wdata(fwd_s4_wdata),
    .fwd_s4_load(fwd_s4_load), .fwd_s4_csr(fwd_s4_csr)
);

endmodule

// File: tb/tb_frv_writeback.sv
/*
 * Self-checking random testbench for the writeback stage. Plays the previous
 * stage, the data memory and the control flow acknowledger, and checks every
 * cycle against a model of the stage kept here.
 */

`timescale 1ns/100ps

module tb_frv_writeback import frv_pkg::*; ();

localparam logic [XL:0] PC_RESET_VALUE = 32'h8000_0000;
localparam int          RET_CNT_W      = 64;
localparam int          NUM_INSTR      = 600;
localparam int          RETIRE_TIMEOUT = 40;   // Cycles allowed per instruction

localparam logic [2:0] K_ALU = 3'd0, K_MUL = 3'd1, K_LOAD = 3'd2, K_STORE = 3'd4;
localparam logic [2:0] K_CFU = 3'd5, K_CSR = 3'd6, K_TRAP = 3'd7;

logic g_clk = 1'b0;
logic g_resetn;
logic s4_valid, s4_busy, s4_trap, gpr_wen, trap_cpu, exec_mret;
logic [4:0] s4_rd, s4_uop, s4_fu, fwd_s4_rd, gpr_rd;
logic [XL:0] s4_opr_a, s4_opr_b, fwd_s4_wdata, gpr_wdata, trap_pc;
logic [1:0] s4_size;
logic [31:0] s4_instr, trs_instr;
logic fwd_s4_load, fwd_s4_csr, csr_en, csr_wr, csr_wr_set, csr_wr_clr;
logic [5:0] trap_cause;
logic [XL:0] csr_mepc, csr_mtvec, csr_wdata, csr_rdata, cf_target, dmem_rdata, trs_pc;
logic [11:0] csr_addr;
logic cf_req, cf_ack, hold_lsu_req, dmem_recv, dmem_ack, dmem_error, trs_valid;
logic [RET_CNT_W-1:0] instret;

logic [31:0]          rng;
logic [XL:0]          model_pc;
logic [RET_CNT_W-1:0] retired;
logic [RET_CNT_W-1:0] trace_cnt;
int                   errors;
int                   checks;
bit                   timed_out;

frv_pipeline_writeback #(
    .PC_RESET_VALUE(PC_RESET_VALUE),
    .RET_CNT_W(RET_CNT_W)
) UUT (.*);

always #5 g_clk = ~g_clk;

// Random source and memory contents
// --------------------------------------------------

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
endtask

function automatic logic [XL:0] mem_word(input logic [XL:0] addr);
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};   // Every address bit matters
endfunction

function automatic logic [XL:0] align_load(input logic [XL:0] word, input logic [1:0] off,
                                           input logic [1:0] size, input logic sgn);
    logic [7:0]  b;
    logic [15:0] h;
    case (off)
        2'd0:    b = word[7:0];
        2'd1:    b = word[15:8];
        2'd2:    b = word[23:16];
        default: b = word[31:24];
    endcase
    h = off[1] ? word[31:16] : word[15:0];
    if (size == LSU_BYTE) begin
        return sgn ? {{24{b[7]}}, b} : {24'd0, b};
    end else if (size == LSU_HALF) begin
        return sgn ? {{16{h[15]}}, h} : {16'd0, h};
    end
    return word;
endfunction

// Compare tasks
// --------------------------------------------------

task automatic report_mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("error at time %0t: %s = %h, expected %h", $time, name, got, exp);
    errors++;
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
endtask

task automatic check_gpr(input logic exp_wen, input logic [4:0] exp_rd,
                         input logic [XL:0] exp_wdata);
    check_flag("gpr_wen", gpr_wen, exp_wen);
    if (exp_wen) begin                       // Data only defined with a write
        checks++;
        if (gpr_rd !== exp_rd) report_mismatch("gpr_rd", 64'(gpr_rd), 64'(exp_rd));
        if (gpr_wdata !== exp_wdata) report_mismatch("gpr_wdata", 64'(gpr_wdata), 64'(exp_wdata));
        if (fwd_s4_rd !== exp_rd) report_mismatch("fwd_s4_rd", 64'(fwd_s4_rd), 64'(exp_rd));
        if (fwd_s4_wdata !== exp_wdata) begin
            report_mismatch("fwd_s4_wdata", 64'(fwd_s4_wdata), 64'(exp_wdata));
        end
    end
endtask

task automatic check_cf(input logic exp_req, input logic [XL:0] exp_target);
    check_flag("cf_req", cf_req, exp_req);
    checks++;
    if (exp_req && cf_target !== exp_target) begin
        report_mismatch("cf_target", 64'(cf_target), 64'(exp_target));
    end
endtask

task automatic check_trap(input logic exp_trap, input logic [5:0] exp_cause,
                          input logic [XL:0] exp_pc);
    check_flag("trap_cpu", trap_cpu, exp_trap);
    checks++;
    if (exp_trap && trap_cause !== exp_cause) begin
        report_mismatch("trap_cause", 64'(trap_cause), 64'(exp_cause));
    end
    if (trap_pc !== exp_pc) report_mismatch("trap_pc", 64'(trap_pc), 64'(exp_pc));
endtask

task automatic check_csr(input logic exp_en, input logic [4:0] uop,
                         input logic [11:0] exp_addr, input logic [XL:0] exp_wdata);
    check_flag("csr_en", csr_en, exp_en);
    check_flag("csr_wr", csr_wr, exp_en && uop[CSR_WRITE]);
    check_flag("csr_wr_set", csr_wr_set, exp_en && uop[CSR_SET]);
    check_flag("csr_wr_clr", csr_wr_clr, exp_en && uop[CSR_CLEAR]);
    if (exp_en) begin                        // Address and data only used with csr_en
        checks++;
        if (csr_addr !== exp_addr) report_mismatch("csr_addr", 64'(csr_addr), 64'(exp_addr));
        if (csr_wdata !== exp_wdata) begin
            report_mismatch("csr_wdata", 64'(csr_wdata), 64'(exp_wdata));
        end
    end
endtask

task automatic check_trace(input logic exp_valid, input logic [XL:0] exp_pc,
                           input logic [31:0] exp_instr);
    check_flag("trs_valid", trs_valid, exp_valid);
    checks++;
    if (trs_pc !== exp_pc) report_mismatch("trs_pc", 64'(trs_pc), 64'(exp_pc));
    if (exp_valid && trs_instr !== exp_instr) begin
        report_mismatch("trs_instr", 64'(trs_instr), 64'(exp_instr));
    end
endtask

task automatic check_count(input string name, input logic [RET_CNT_W-1:0] got,
                           input logic [RET_CNT_W-1:0] exp);
    checks++;
    if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
endtask

// Stimulus
// --------------------------------------------------

task automatic idle_cycle();
    s4_valid   = 1'b0;
    s4_fu      = '0;
    s4_trap    = 1'b0;
    dmem_recv  = 1'b0;
    dmem_error = 1'b0;
    cf_ack     = 1'b0;
    #1;
    check_flag("s4_busy", s4_busy, 1'b0);
    check_trace(1'b0, model_pc, s4_instr);
    check_flag("dmem_ack", dmem_ack, 1'b0);
    check_csr(1'b0, '0, '0, '0);
    check_gpr(1'b0, s4_rd, '0);
    check_cf(1'b0, '0);
    check_trap(1'b0, '0, model_pc);
    if (trs_valid === 1'b1) trace_cnt = trace_cnt + RET_CNT_W'(1);
    @(posedge g_clk);
    @(negedge g_clk);
endtask

task automatic run_instr(input int idx);
    logic [31:0] r;
    logic [31:0] addr;
    logic [2:0]  kind;
    logic [4:0]  cfu_op;
    logic [1:0]  lsz;
    logic [1:0]  off;
    logic        bus_err;
    logic        is_lsu;
    logic        is_jump;
    logic        is_link;
    logic        is_mret;
    logic        resp_now;
    logic        resp_taken;
    logic        err_pend;
    logic        exp_busy;
    logic        exp_req;
    logic        exp_trap;
    logic        exp_wen;
    logic [5:0]  exp_cause;
    logic [XL:0] exp_target;
    logic [XL:0] exp_wdata;
    logic [XL:0] seq_pc;
    int          mem_dly;
    int          ack_dly;
    int          ack_cnt;
    int          cyc;
    bit          done;

    next_rand(r);
    kind = (r[2:0] == 3'd3) ? K_LOAD : r[2:0];     // Loads get two slots
    next_rand(r);
    s4_opr_a = r;
    next_rand(r);
    addr = r;
    next_rand(r);
    s4_rd   = r[4:0];
    s4_size = r[5] ? 2'b10 : 2'b01;
    lsz     = (r[7:6] == 2'b00) ? LSU_WORD : r[7:6];
    bus_err = (r[11:9] == 3'd0);
    mem_dly = int'(r[14:12]) % 6;
    ack_dly = int'(r[17:15]) % 6;
    case (r[20:18])
        3'd0:    cfu_op = CFU_TAKEN;
        3'd1:    cfu_op = CFU_JALI;
        3'd2:    cfu_op = CFU_JALR;
        3'd3:    cfu_op = CFU_MRET;
        3'd4:    cfu_op = CFU_ECALL;
        3'd5:    cfu_op = CFU_EBREAK;
        default: cfu_op = 5'b01000;               // Branch not taken
    endcase
    off = (lsz == LSU_BYTE) ? addr[1:0] : (lsz == LSU_HALF) ? {addr[1], 1'b0} : 2'b00;
    s4_opr_b   = {addr[31:2], off};
    dmem_rdata = mem_word({addr[31:2], 2'b00});
    s4_fu = '0;
    case (kind)
        K_MUL:   s4_fu[P_FU_MUL] = 1'b1;
        K_LOAD:  s4_fu[P_FU_LSU] = 1'b1;
        K_STORE: s4_fu[P_FU_LSU] = 1'b1;
        K_CFU:   s4_fu[P_FU_CFU] = 1'b1;
        K_CSR:   s4_fu[P_FU_CSR] = 1'b1;
        default: s4_fu[P_FU_ALU] = 1'b1;
    endcase
    case (kind)
        K_LOAD:  s4_uop = {2'b01, lsz, r[8]};
        K_STORE: s4_uop = {2'b10, lsz, 1'b0};
        K_CFU:   s4_uop = cfu_op;
        default: s4_uop = r[25:21];
    endcase
    next_rand(r);
    s4_instr = r;
    next_rand(r);
    csr_rdata = r;
    next_rand(r);
    csr_mtvec = r;
    next_rand(r);
    csr_mepc = r;
    s4_trap  = (kind == K_TRAP);
    s4_valid = 1'b1;

    seq_pc  = model_pc + XLEN'(s4_size) * 2;      // Size counts halfwords
    is_lsu  = (kind == K_LOAD) || (kind == K_STORE);
    is_link = (kind == K_CFU) && (cfu_op == CFU_JALI || cfu_op == CFU_JALR);
    is_jump = is_link || ((kind == K_CFU) && cfu_op == CFU_TAKEN);
    is_mret = (kind == K_CFU) && (cfu_op == CFU_MRET);
    resp_taken = 1'b0;
    err_pend   = 1'b0;
    ack_cnt    = 0;
    cyc        = 0;
    done       = 1'b0;

    while (!done) begin
        if (cyc >= RETIRE_TIMEOUT) begin
            $display("Timed out: instruction %0d did not retire within %0d cycles",
                     idx, RETIRE_TIMEOUT);
            errors++;
            timed_out = 1'b1;
            break;
        end
        // Memory responder and control flow acknowledger
        dmem_recv  = is_lsu && !resp_taken && (cyc == mem_dly);
        dmem_error = dmem_recv && bus_err;
        cf_ack     = (ack_cnt >= ack_dly);
        #1;
        resp_now   = dmem_recv;
        exp_trap   = s4_trap || err_pend || (resp_now && bus_err) ||
                     ((kind == K_CFU) && (cfu_op == CFU_ECALL || cfu_op == CFU_EBREAK));
        exp_req    = is_jump || is_mret || exp_trap;
        exp_target = exp_trap ? csr_mtvec : is_mret ? csr_mepc : s4_opr_a;
        if (err_pend || (resp_now && bus_err)) begin
            exp_cause = (kind == K_STORE) ? 6'd7 : 6'd5;
        end else if ((kind == K_CFU) && cfu_op == CFU_EBREAK) begin
            exp_cause = 6'd3;
        end else if ((kind == K_CFU) && cfu_op == CFU_ECALL) begin
            exp_cause = 6'd11;
        end else begin
            exp_cause = s4_opr_a[5:0];            // Cause carried from upstream
        end
        exp_busy = (is_lsu && !resp_taken && !resp_now) || (exp_req && !cf_ack);
        case (kind)
            K_ALU, K_MUL: exp_wen = 1'b1;
            K_CSR:        exp_wen = s4_uop[CSR_READ];
            K_CFU:        exp_wen = is_link;
            K_LOAD:       exp_wen = resp_now && !bus_err;
            default:      exp_wen = 1'b0;
        endcase
        case (kind)
            K_CSR:   exp_wdata = csr_rdata;
            K_CFU:   exp_wdata = seq_pc;
            K_LOAD:  exp_wdata = align_load(dmem_rdata, off, lsz, s4_uop[LSU_SIGNED]);
            default: exp_wdata = s4_opr_a;
        endcase

        check_flag("s4_busy", s4_busy, exp_busy);
        check_trace(!exp_busy, model_pc, s4_instr);
        check_flag("dmem_ack", dmem_ack, is_lsu && !resp_taken);
        check_flag("hold_lsu_req", hold_lsu_req, exp_req || (is_lsu && !resp_taken));
        check_flag("exec_mret", exec_mret, is_mret && !exp_busy);
        check_csr(kind == K_CSR, s4_uop, s4_opr_b[11:0], s4_opr_a);
        check_flag("fwd_s4_load", fwd_s4_load, kind == K_LOAD);
        check_flag("fwd_s4_csr", fwd_s4_csr, kind == K_CSR);
        check_gpr(exp_wen, s4_rd, exp_wdata);
        check_cf(exp_req, exp_target);
        check_trap(exp_trap, exp_cause, model_pc);
        if (trs_valid === 1'b1) trace_cnt = trace_cnt + RET_CNT_W'(1);

        if (!exp_busy) begin                      // Retire cycle
            done     = 1'b1;
            retired  = retired + RET_CNT_W'(1);
            model_pc = exp_req ? exp_target : seq_pc;
        end else begin
            if (resp_now) resp_taken = 1'b1;
            if (resp_now && bus_err) err_pend = 1'b1;
            if (exp_req) ack_cnt++;
        end
        cyc++;
        @(posedge g_clk);
        @(negedge g_clk);
    end
endtask

// Main sequence
// --------------------------------------------------

initial begin
    logic [31:0] r;
    g_resetn   = 1'b0;
    s4_valid   = 1'b0;
    s4_rd      = '0;
    s4_opr_a   = '0;
    s4_opr_b   = '0;
    s4_uop     = '0;
    s4_fu      = '0;
    s4_trap    = 1'b0;
    s4_size    = '0;
    s4_instr   = '0;
    csr_mepc   = '0;
    csr_mtvec  = '0;
    csr_rdata  = '0;
    cf_ack     = 1'b0;
    dmem_recv  = 1'b0;
    dmem_error = 1'b0;
    dmem_rdata = '0;
    rng        = 32'd30;
    model_pc   = PC_RESET_VALUE;
    retired    = '0;
    trace_cnt  = '0;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;

    repeat (10) @(posedge g_clk);
    @(negedge g_clk);
    g_resetn = 1'b1;
    idle_cycle();
    check_count("instret", instret, '0);

    for (int n = 0; n < NUM_INSTR && !timed_out; n++) begin
        run_instr(n);
        next_rand(r);
        if (r[2:0] == 3'd0) idle_cycle();      // Occasional bubble
    end

    check_count("instret", instret, retired);
    check_count("trs_valid cycles", trace_cnt, retired);

    $display("Checks: %0d, errors: %0d, retired: %0d", checks, errors, retired);
    if (errors == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

// File: vlog.f
verilog/frv_pkg.sv
verilog/frv_wb_ctrl.sv
verilog/frv_wb_cf_unit.sv
verilog/frv_wb_load_align.sv
verilog/frv_retire_counter.sv
verilog/frv_wb_gpr_select.sv
verilog/frv_pipeline_writeback.sv
tb/tb_frv_writeback.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the writeback stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_frv_writeback

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" \
    --Mdir obj_dir -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
STATUS=$?
cat "$LOG"

if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
